// ==== filelist.f ====
spindle_pkg.sv
param_regs.sv
spi_slave.sv
tick_gen.sv
spindle_rate.sv
spindle_board.sv
spindle_props.sv
spindle_checker.sv
tb_spindle_board.sv

// ==== Makefile ====
# Verilator flow for the spindle board

VERILATOR   ?= verilator
FILELIST    ?= filelist.f
TB_TOP      ?= tb_spindle_board
RTL_TOP     ?= spindle_board
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
PASS_TEXT   ?= All tests passed
LINT_FLAGS  ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# result comes from the log, not from the exit code of the model
sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_spindle_board.sv ====
`timescale 1ns/1ps

module tb_spindle_board;

    // cycle budget, one 32-bit frame with gaps and one settle wait
    localparam int frame_cycles  = 8 + spindle_pkg::frame_bits * 8 + 24;
    localparam int settle_cycles = 64;
    localparam int load_cycles   = 4;
    localparam int run_cycles    = 16 + 14 * frame_cycles + 8 * settle_cycles
                                   + 8 * load_cycles;
    localparam int cycle_limit   = 2 * run_cycles;

    logic               ep50trig = 1'b0;
    logic               reset_global;
    logic [15:0]        host_trig;
    logic [15:0]        wire_lo;
    logic [15:0]        wire_hi;
    logic               sck;
    logic               mosi;
    logic               ssel;
    logic               miso;
    spindle_pkg::fix_t  muscle_len;
    spindle_pkg::fix_t  rate_ia;
    spindle_pkg::fix_t  rate_ii;
    logic               frame_rdy;
    logic [7:0]         led;

    // requests to the checker
    spindle_pkg::fix_t  ref_len;
    spindle_pkg::word_t miso_word;
    int                 exp_frames;
    logic [3:0]         check_sel;
    logic               test_end;
    int                 test_num;
    int                 check_count;
    int                 error_count;

    spindle_pkg::word_t lcg_state = 32'd4;
    int                 cycles = 0;

    always #10 ep50trig = ~ep50trig;

    spindle_board u_spindle_board (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .host_trig    (host_trig),
        .wire_lo      (wire_lo),
        .wire_hi      (wire_hi),
        .sck          (sck),
        .mosi         (mosi),
        .ssel         (ssel),
        .miso         (miso),
        .muscle_len   (muscle_len),
        .rate_ia      (rate_ia),
        .rate_ii      (rate_ii),
        .frame_rdy    (frame_rdy),
        .led          (led)
    );

    spindle_checker u_checker (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .host_trig    (host_trig),
        .wire_lo      (wire_lo),
        .wire_hi      (wire_hi),
        .muscle_len   (muscle_len),
        .rate_ia      (rate_ia),
        .rate_ii      (rate_ii),
        .frame_rdy    (frame_rdy),
        .led          (led),
        .ref_len      (ref_len),
        .miso_word    (miso_word),
        .exp_frames   (exp_frames),
        .check_sel    (check_sel),
        .test_end     (test_end),
        .test_num     (test_num),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    // link strobe and model tick watched from the top scope
    bind spindle_board spindle_props u_spindle_props (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .ssel         (ssel),
        .frame_rdy    (frame_rdy),
        .tick         (tick)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic spindle_pkg::word_t lcg_next(input spindle_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random(output spindle_pkg::word_t r);
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge ep50trig);
    endtask

    task automatic load_host(input logic [15:0] trig, input spindle_pkg::word_t value);
        wire_hi   = value[31:16];
        wire_lo   = value[15:0];
        host_trig = trig;
        @(negedge ep50trig);
        host_trig = 16'h0000;
        @(negedge ep50trig);
    endtask

    // mode 0 master, msb first, sck half period of 4 clocks
    task automatic spi_transfer(
        input  spindle_pkg::word_t tx,
        input  int                 nbits,
        output spindle_pkg::word_t rx
    );
        int k;
        rx   = '0;
        ssel = 1'b0;
        wait_cycles(8);
        for (k = 0; k < nbits; k++)
        begin
            mosi = tx[31 - k];
            wait_cycles(4);
            // miso settled since the last falling sck
            rx  = {rx[30:0], miso};
            sck = 1'b1;
            wait_cycles(4);
            sck = 1'b0;
        end
        mosi = 1'b0;
        wait_cycles(4);
        ssel = 1'b1;
    endtask

    task automatic send_frame(input spindle_pkg::word_t tx, output spindle_pkg::word_t rx);
        int n;
        spi_transfer(tx, spindle_pkg::frame_bits, rx);
        n = 0;
        // bounded wait for the commit strobe
        while (!frame_rdy && (n < 16))
        begin
            @(negedge ep50trig);
            n++;
        end
        wait_cycles(4);
    endtask

    task automatic pulse_check(input logic [3:0] sel);
        check_sel = sel;
        @(negedge ep50trig);
        check_sel = 4'b0000;
    endtask

    task automatic end_test(input int num);
        test_num = num;
        test_end = 1'b1;
        @(negedge ep50trig);
        test_end = 1'b0;
    endtask

    // run limit
    always @(posedge ep50trig)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        spindle_pkg::word_t r;
        spindle_pkg::word_t rx;
        int                 assert_fails;
        reset_global = 1'b1;
        host_trig    = 16'h0000;
        wire_lo      = 16'h0000;
        wire_hi      = 16'h0000;
        sck          = 1'b0;
        mosi         = 1'b0;
        ssel         = 1'b1;
        ref_len      = '0;
        miso_word    = '0;
        exp_frames   = 0;
        check_sel    = 4'b0000;
        test_end     = 1'b0;
        test_num     = 0;
        wait_cycles(16);
        reset_global = 1'b0;
        wait_cycles(2);

        // zero length sits below the default reference
        pulse_check(4'b1011);
        wait_cycles(settle_cycles);
        pulse_check(4'b1011);
        end_test(1);

        repeat (8)
        begin
            next_random(r);
            send_frame(r, rx);
            ref_len = r;
            exp_frames++;
            pulse_check(4'b1001);
        end
        end_test(2);

        // 3.5 gives ia 2.5, ii 1.25
        send_frame(32'h0003_8000, rx);
        ref_len = 32'h0003_8000;
        exp_frames++;
        wait_cycles(settle_cycles);
        pulse_check(4'b1011);
        // below the reference
        send_frame(32'h0000_8000, rx);
        ref_len = 32'h0000_8000;
        exp_frames++;
        wait_cycles(settle_cycles);
        pulse_check(4'b1011);
        // gain 4.0 on a long muscle clips ia
        load_host(16'h0001 << spindle_pkg::trig_gain_ia, 32'h0004_0000);
        send_frame(32'hF000_0000, rx);
        ref_len = 32'hF000_0000;
        exp_frames++;
        wait_cycles(settle_cycles);
        pulse_check(4'b1011);
        end_test(3);

        // gains up to 16.0, reference up to 4.0
        next_random(r);
        load_host(16'h0001 << spindle_pkg::trig_gain_ia, r & 32'h000F_FFFF);
        next_random(r);
        load_host(16'h0001 << spindle_pkg::trig_gain_ii, r & 32'h000F_FFFF);
        next_random(r);
        load_host(16'h0001 << spindle_pkg::trig_len_ref, r & 32'h0003_FFFF);
        // bits with no register behind them
        next_random(r);
        load_host(16'hFF71, r);
        next_random(r);
        r = (r & 32'h00FF_FFFF) | 32'h0010_0000;
        send_frame(r, rx);
        ref_len = r;
        exp_frames++;
        wait_cycles(settle_cycles);
        pulse_check(4'b1011);
        end_test(4);

        // reply carries the rate of the length still in ref_len
        next_random(r);
        send_frame(r, rx);
        miso_word = rx;
        pulse_check(4'b0100);
        ref_len = r;
        exp_frames++;
        pulse_check(4'b1001);
        end_test(5);

        // 20 bits, length and count stay put
        next_random(r);
        spi_transfer(r, 20, rx);
        wait_cycles(16);
        pulse_check(4'b1001);
        end_test(6);

        wait_cycles(4);
        assert_fails = u_spindle_board.u_spindle_props.rdy_width_fails
                     + u_spindle_board.u_spindle_props.rdy_ssel_fails
                     + u_spindle_board.u_spindle_props.tick_width_fails;
        $display("summary: 6 tests, %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, assert_fails);
        if ((error_count == 0) && (assert_fails == 0))
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== spindle_checker.sv ====
`timescale 1ns/1ps

module spindle_checker (
    input  logic               ep50trig,
    input  logic               reset_global,
    input  logic [15:0]        host_trig,
    input  logic [15:0]        wire_lo,
    input  logic [15:0]        wire_hi,
    input  spindle_pkg::fix_t  muscle_len,
    input  spindle_pkg::fix_t  rate_ia,
    input  spindle_pkg::fix_t  rate_ii,
    input  logic               frame_rdy,
    input  logic [7:0]         led,
    input  spindle_pkg::fix_t  ref_len,
    input  spindle_pkg::word_t miso_word,
    input  int                 exp_frames,
    input  logic [3:0]         check_sel,
    input  logic               test_end,
    input  int                 test_num,
    output int                 check_count,
    output int                 error_count
);

    // what the host has loaded so far
    spindle_pkg::spindle_params_t model;
    int                           frames_seen;
    int                           test_checks;
    int                           test_errors;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // stretch above ref times gain, q16.16, clipped at the ceiling
    function automatic spindle_pkg::fix_t rate_ref(
        input spindle_pkg::fix_t len,
        input spindle_pkg::fix_t len_ref,
        input spindle_pkg::fix_t gain
    );
        logic [63:0] stretch;
        logic [63:0] scaled;
        if (len <= len_ref)
        begin
            return '0;
        end
        stretch = {32'h0, len - len_ref};
        scaled  = (stretch * {32'h0, gain}) >> 16;
        if (scaled > {32'h0, spindle_pkg::rate_max})
        begin
            return spindle_pkg::rate_max;
        end
        return scaled[31:0];
    endfunction

    function automatic string test_name(input int num);
        case (num)
            1:       return "reset state";
            2:       return "random frames";
            3:       return "default model";
            4:       return "host loads";
            5:       return "miso readback";
            6:       return "short frame";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare(
        input string              name,
        input spindle_pkg::word_t expected,
        input spindle_pkg::word_t actual
    );
        check_count++;
        test_checks++;
        if (expected !== actual)
        begin
            error_count++;
            test_errors++;
            $display("[ERROR] %0d ns %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // host trigger rule: each bit loads its own field, others ignored
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            model.gain_ia  <= spindle_pkg::def_gain_ia;
            model.gain_ii  <= spindle_pkg::def_gain_ii;
            model.len_ref  <= spindle_pkg::def_len_ref;
            model.half_cnt <= spindle_pkg::def_half_cnt;
        end
        else
        begin
            if (host_trig[spindle_pkg::trig_gain_ia])
            begin
                model.gain_ia <= {wire_hi, wire_lo};
            end
            if (host_trig[spindle_pkg::trig_gain_ii])
            begin
                model.gain_ii <= {wire_hi, wire_lo};
            end
            if (host_trig[spindle_pkg::trig_len_ref])
            begin
                model.len_ref <= {wire_hi, wire_lo};
            end
            if (host_trig[spindle_pkg::trig_half_cnt])
            begin
                model.half_cnt <= {wire_hi[7:0], wire_lo};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare on request
    ////////////////////////////////////////////////////////////////////////////

    // check_sel: [0] length, [1] rates, [2] miso word, [3] frame count
    always @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            frames_seen = 0;
            test_checks = 0;
            test_errors = 0;
            check_count = 0;
            error_count = 0;
        end
        else
        begin
            if (check_sel[0])
            begin
                compare("muscle_len", ref_len, muscle_len);
            end
            if (check_sel[1])
            begin
                compare("rate_ia", rate_ref(ref_len, model.len_ref, model.gain_ia), rate_ia);
                compare("rate_ii", rate_ref(ref_len, model.len_ref, model.gain_ii), rate_ii);
            end
            // reply word is the ia rate of the previous length
            if (check_sel[2])
            begin
                compare("miso", rate_ref(ref_len, model.len_ref, model.gain_ia), miso_word);
            end
            if (check_sel[3])
            begin
                compare("frame_rdy count", 32'(exp_frames), 32'(frames_seen));
                // active low, reset led dark, frame led flips per good frame
                compare("led", 32'({1'b1, ~exp_frames[0], 6'b111111}), 32'(led));
            end
            if (frame_rdy)
            begin
                frames_seen++;
            end
            if (test_end)
            begin
                $display("test %0d %s: %0d checks, %0d errors, %s", test_num,
                         test_name(test_num), test_checks, test_errors,
                         (test_errors == 0) ? "ok" : "FAILED");
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

// ==== spindle_props.sv ====
`timescale 1ns/1ps

module spindle_props (
    input logic ep50trig,
    input logic reset_global,
    input logic ssel,
    input logic frame_rdy,
    input logic tick
);

    // failure tallies, read by the testbench at the end
    int rdy_width_fails = 0;
    int rdy_ssel_fails = 0;
    int tick_width_fails = 0;

    // good frame strobe lasts one cycle
    rdy_one_cycle: assert property (@(posedge ep50trig) disable iff (reset_global)
        frame_rdy |=> !frame_rdy)
    else
    begin
        rdy_width_fails++;
        $error("frame_rdy held high for more than one cycle");
    end

    // commit only after the master lets go of ssel
    rdy_after_ssel: assert property (@(posedge ep50trig) disable iff (reset_global)
        frame_rdy |-> ssel)
    else
    begin
        rdy_ssel_fails++;
        $error("frame_rdy pulsed while ssel was low");
    end

    // model tick
    tick_one_cycle: assert property (@(posedge ep50trig) disable iff (reset_global)
        tick |=> !tick)
    else
    begin
        tick_width_fails++;
        $error("tick held high for more than one cycle");
    end

endmodule

// ==== spindle_board.sv ====
`timescale 1ns/1ps

module spindle_board (
    input  logic              ep50trig,
    input  logic              reset_global,
    input  logic [15:0]       host_trig,
    input  logic [15:0]       wire_lo,
    input  logic [15:0]       wire_hi,
    input  logic              sck,
    input  logic              mosi,
    input  logic              ssel,
    output logic              miso,
    output spindle_pkg::fix_t muscle_len,
    output spindle_pkg::fix_t rate_ia,
    output spindle_pkg::fix_t rate_ii,
    output logic              frame_rdy,
    output logic [7:0]        led
);

    spindle_pkg::spindle_params_t params;
    logic                         frame_start;
    logic                         tick;

    ////////////////////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////////////////////

    // host loaded coefficients
    param_regs u_param_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .host_trig    (host_trig),
        .wire_lo      (wire_lo),
        .wire_hi      (wire_hi),
        .params       (params)
    );

    // peer board link, ia rate goes back as reply
    spi_slave u_spi_slave (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sck          (sck),
        .mosi         (mosi),
        .ssel         (ssel),
        .miso         (miso),
        .tx_word      (rate_ia),
        .muscle_len   (muscle_len),
        .frame_rdy    (frame_rdy),
        .frame_start  (frame_start)
    );

    tick_gen u_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .half_cnt     (params.half_cnt),
        .frame_start  (frame_start),
        .tick         (tick)
    );

    spindle_rate u_spindle_rate (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .tick         (tick),
        .muscle_len   (muscle_len),
        .params       (params),
        .rate_ia      (rate_ia),
        .rate_ii      (rate_ii)
    );

    ////////////////////////////////////////////////////////////////////////////
    // leds, active low
    ////////////////////////////////////////////////////////////////////////////

    // flips once per good frame
    logic frame_led;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            frame_led <= 1'b0;
        end
        else if (frame_rdy)
        begin
            frame_led <= ~frame_led;
        end
    end

    assign led[7]   = ~reset_global;
    assign led[6]   = ~frame_led;
    // unused leds off
    assign led[5:0] = 6'b111111;

endmodule

// ==== spindle_rate.sv ====
`timescale 1ns/1ps

module spindle_rate (
    input  logic                         ep50trig,
    input  logic                         reset_global,
    input  logic                         tick,
    input  spindle_pkg::fix_t            muscle_len,
    input  spindle_pkg::spindle_params_t params,
    output spindle_pkg::fix_t            rate_ia,
    output spindle_pkg::fix_t            rate_ii
);

    ////////////////////////////////////////////////////////////////////////////
    // linear afferent model
    ////////////////////////////////////////////////////////////////////////////

    // q16.16 multiply, floor, clamp to 32 bits
    function automatic spindle_pkg::fix_t scale_sat(
        input spindle_pkg::fix_t stretch_in,
        input spindle_pkg::fix_t gain
    );
        logic [63:0] prod;
        prod = 64'(stretch_in) * 64'(gain);
        // anything above bit 47 overflows after the >>16
        if (prod[63:48] != 16'h0000)
        begin
            return spindle_pkg::rate_max;
        end
        return prod[47:16];
    endfunction

    // length above reference, zero when not stretched
    spindle_pkg::fix_t stretch;

    always_comb
    begin
        if (muscle_len > params.len_ref)
        begin
            stretch = muscle_len - params.len_ref;
        end
        else
        begin
            stretch = '0;
        end
    end

    // rates move only on model ticks
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            rate_ia <= '0;
            rate_ii <= '0;
        end
        else if (tick)
        begin
            rate_ia <= scale_sat(stretch, params.gain_ia);
            rate_ii <= scale_sat(stretch, params.gain_ii);
        end
    end

endmodule

// ==== tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen (
    input  logic               ep50trig,
    input  logic               reset_global,
    input  spindle_pkg::half_t half_cnt,
    input  logic               frame_start,
    output logic               tick
);

    // cycle count within a half period
    spindle_pkg::half_t cnt;
    // 0 first half, 1 second half
    logic phase;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            cnt   <= '0;
            phase <= 1'b0;
            tick  <= 1'b0;
        end
        else if (frame_start)
        begin
            // realign to the peer board frame
            cnt   <= '0;
            phase <= 1'b0;
            tick  <= 1'b0;
        end
        else if (cnt >= half_cnt)
        begin
            // end of a half period
            cnt   <= '0;
            phase <= ~phase;
            // tick only after the second half
            tick  <= phase;
        end
        else
        begin
            cnt  <= cnt + 24'd1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== spi_slave.sv ====
`timescale 1ns/1ps

module spi_slave (
    input  logic              ep50trig,
    input  logic              reset_global,
    input  logic              sck,
    input  logic              mosi,
    input  logic              ssel,
    output logic              miso,
    input  spindle_pkg::fix_t tx_word,
    output spindle_pkg::fix_t muscle_len,
    output logic              frame_rdy,
    output logic              frame_start
);

    ////////////////////////////////////////////////////////////////////////////
    // pin synchronizers
    ////////////////////////////////////////////////////////////////////////////

    // [0] metastable stage, [1] synced, [2] previous synced for edges
    logic [2:0] sck_q;
    logic [2:0] ssel_q;
    logic [1:0] mosi_q;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            // idle bus, ssel deasserted
            sck_q  <= 3'b000;
            ssel_q <= 3'b111;
            mosi_q <= 2'b00;
        end
        else
        begin
            sck_q  <= {sck_q[1:0], sck};
            ssel_q <= {ssel_q[1:0], ssel};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    logic sck_rise;
    logic sck_fall;
    logic ssel_fall;
    logic ssel_rise;

    assign sck_rise  = sck_q[1] & ~sck_q[2];
    assign sck_fall  = ~sck_q[1] & sck_q[2];
    assign ssel_fall = ~ssel_q[1] & ssel_q[2];
    assign ssel_rise = ssel_q[1] & ~ssel_q[2];

    ////////////////////////////////////////////////////////////////////////////
    // frame fsm and shifters
    ////////////////////////////////////////////////////////////////////////////

    spindle_pkg::spi_state_t state;
    logic [5:0]              bit_cnt;
    spindle_pkg::word_t      rx_shift;
    spindle_pkg::word_t      tx_shift;

    // payload shifters, no reset
    always_ff @(posedge ep50trig)
    begin
        if ((state != spindle_pkg::shift) && ssel_fall)
        begin
            // reply word latched at frame start
            tx_shift <= tx_word;
        end
        else if ((state == spindle_pkg::shift) && sck_fall)
        begin
            tx_shift <= {tx_shift[30:0], 1'b0};
        end
        // msb first in
        if ((state == spindle_pkg::shift) && sck_rise)
        begin
            rx_shift <= {rx_shift[30:0], mosi_q[1]};
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            state       <= spindle_pkg::idle;
            bit_cnt     <= '0;
            miso        <= 1'b0;
            muscle_len  <= '0;
            frame_rdy   <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            frame_rdy   <= 1'b0;
            frame_start <= 1'b0;
            case (state)
                spindle_pkg::shift:
                begin
                    if (ssel_rise)
                    begin
                        // commit only a full frame
                        if (bit_cnt == 6'(spindle_pkg::frame_bits))
                        begin
                            muscle_len <= rx_shift;
                            frame_rdy  <= 1'b1;
                        end
                        miso  <= 1'b0;
                        state <= spindle_pkg::done;
                    end
                    else
                    begin
                        // count saturates so long frames never alias to 32
                        if (sck_rise && (bit_cnt != 6'h3F))
                        begin
                            bit_cnt <= bit_cnt + 6'd1;
                        end
                        // next bit out on falling sck
                        if (sck_fall)
                        begin
                            miso <= tx_shift[30];
                        end
                    end
                end
                default:
                begin
                    // idle or done, wait for ssel to drop
                    state <= spindle_pkg::idle;
                    if (ssel_fall)
                    begin
                        frame_start <= 1'b1;
                        bit_cnt     <= '0;
                        miso        <= tx_word[31];
                        state       <= spindle_pkg::shift;
                    end
                end
            endcase
        end
    end

endmodule

// ==== param_regs.sv ====
`timescale 1ns/1ps

module param_regs (
    input  logic                         ep50trig,
    input  logic                         reset_global,
    input  logic [15:0]                  host_trig,
    input  logic [15:0]                  wire_lo,
    input  logic [15:0]                  wire_hi,
    output spindle_pkg::spindle_params_t params
);

    // host word, high half from the second wire-in
    spindle_pkg::word_t load_word;

    assign load_word = {wire_hi, wire_lo};

    ////////////////////////////////////////////////////////////////////////////
    // coefficient registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            // defaults give a usable model with no host writes
            params.gain_ia  <= spindle_pkg::def_gain_ia;
            params.gain_ii  <= spindle_pkg::def_gain_ii;
            params.len_ref  <= spindle_pkg::def_len_ref;
            params.half_cnt <= spindle_pkg::def_half_cnt;
        end
        else
        begin
            // ia gain
            if (host_trig[spindle_pkg::trig_gain_ia])
            begin
                params.gain_ia <= load_word;
            end
            // ii gain
            if (host_trig[spindle_pkg::trig_gain_ii])
            begin
                params.gain_ii <= load_word;
            end
            // reference length, zero stretch point
            if (host_trig[spindle_pkg::trig_len_ref])
            begin
                params.len_ref <= load_word;
            end
            // tick half period, only low 24 bits kept
            if (host_trig[spindle_pkg::trig_half_cnt])
            begin
                params.half_cnt <= load_word[$bits(spindle_pkg::half_t)-1:0];
            end
            // remaining trigger bits have no register here
        end
    end

endmodule

// ==== spindle_pkg.sv ====
package spindle_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////////////////////

    // one spi frame or one raw coefficient word
    typedef logic [31:0] word_t;
    // q16.16 value, unsigned
    typedef logic [31:0] fix_t;
    // tick half-period count
    typedef logic [23:0] half_t;

    // model coefficients, loaded by host triggers
    typedef struct packed {
        fix_t  gain_ia;
        fix_t  gain_ii;
        fix_t  len_ref;
        half_t half_cnt;
    } spindle_params_t;

    // trigger vector bit positions
    localparam int trig_gain_ia  = 1;
    localparam int trig_gain_ii  = 2;
    localparam int trig_len_ref  = 3;
    localparam int trig_half_cnt = 7;

    // reset values: gain 1.0, gain 0.5, length 1.0
    localparam fix_t  def_gain_ia  = 32'h0001_0000;
    localparam fix_t  def_gain_ii  = 32'h0000_8000;
    localparam fix_t  def_len_ref  = 32'h0001_0000;
    localparam half_t def_half_cnt = 24'd13;

    // bits per spi frame
    localparam int frame_bits = 32;
    // rate saturation ceiling
    localparam fix_t rate_max = 32'hFFFF_FFFF;

    // spi slave fsm
    typedef enum logic [1:0] {idle, shift, done} spi_state_t;

endpackage
